// ==== boot_image.hex ====
// One 64-bit boot ROM word per line in hex, starting at ROM address 0
8f3a0c11d2e45b70
17c4e9a05b38f2d1
a2d65f1e09c7b384
4b90e3d7a1f2605c
d13f7a2c8e04b9e6
6e85c0b49d1a7f23
f04b2d6e7c9358a1
29e7a8135fb0c4de
c58d1f40e62a9b37
73a2b6c9d0e815f4
be16d4f2a7839c05
0d7f53a8c1b6e249
e9c3108bf45da762
5a48e7d20cf391b8
91bd6c3a8e2f4075
36f0a95d1b7ce8c2
fc2e8b17d490a563
84d519e6a3c07f2b
1f6ac4b83e95d270
c7039d5fe2a18b46
5b9e27a0c6d43f81
e24f8c3b917a06d5
70c1d5e84bf2a93e
ad8736f2c05e1b49
0293fa4e6d8bc715
db54e1a97f3608c2
68ad0c2fb1e4795d
b1f7932d4ac8e063
4fe26b8093d57a1c
c83d14f7e26ab905
19a7e5c20d4f83b6
f56b28d9c71e4a30
8e0d3a64f2b5c917
27c9f18b5ea0d364
d4826ec3a917f05b
6b1e0f975cd832a4
a95cb3482ef60d17
3e07d6a19b4c5f82
f7a4195e8d2b60c3
520c8be736f9a41d
c1e96d2a04b8f375
8d3bf0c65a17e29e
14f652a7e9d0bc38
e86a0d3fc4259b71
7b2dc8916fe03a54
a05e37b4d18c926f
36c9e45f0b7a1d82
fd81a26c93e54b07
92475eb81dc06af3
4e1cb9d0a7f2385c
cb6f0483e52d9a17
0a93d7f25c8e416b
e5284ac16b9f0d3e
71d6ef3890a4c5b2
bc0a3951f7e8624d
2f7b84e6c3d190a8
d93e6b0a2185f7c4
6084f1c9be3a2d57
a7c52d8e4f096b13
15ef9a3b70c8d4e6
fa60c7e2d934815b
83b92f054ae6c7d1
4c2d86a1f7b039e8
e1f45b7c08d2a693

// ==== boot_loader.f ====
verilog/boot_pkg.sv
verilog/boot_rom.sv
verilog/word_counter.sv
verilog/copy_fsm.sv
verilog/copy_datapath.sv
verilog/boot_loader.sv
verification/boot_loader_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the boot loader testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" &&
  verilator --binary --timing --timescale 1ns/1ps \
    --top-module boot_loader_tb \
    -f boot_loader.f \
    -o boot_loader_sim &&
  ./obj_dir/boot_loader_sim ||
  {
    echo "Build or simulation ended with an error" >&2
    exit 1
  }

// ==== verification/boot_loader_tb.sv ====
/*
  Testbench for the boot loader with a reference model of the ROM copy,
  seeded random requests, compare tasks and a watchdog
*/

`timescale 1ns/1ps

module boot_loader_tb;

  import boot_pkg::*;

  // ------------------------------------------------------------
  // Run length and time limit
  // ------------------------------------------------------------

  localparam int clk_period_ns = 4;
  localparam int num_directed  = 6;
  localparam int num_random    = 200;

  // Every request ends within 64 words plus a few cycles of overhead and gap
  localparam int watchdog_ns =
    (num_directed + num_random) * (rom_depth + 10) * clk_period_ns + 2000;

  // DUT ports
  logic          clk;
  logic          reset;
  logic          start;
  boot_request_t request;
  logic          busy;
  logic          mem_we;
  mem_write_t    mem_write;
  logic          done;
  checksum_t     checksum;

  // Reference model state
  data_word_t model_rom [rom_depth];
  mem_write_t exp_writes [rom_depth];
  checksum_t  exp_sum;
  checksum_t  last_sum;

  boot_loader UUT (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .request   (request),
    .busy      (busy),
    .mem_we    (mem_we),
    .mem_write (mem_write),
    .done      (done),
    .checksum  (checksum)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // ------------------------------------------------------------
  // Failure reporting and compare tasks
  // ------------------------------------------------------------

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_write(input string name, input mem_write_t expected,
                             input mem_write_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("[FAIL] %s expected addr %h data %h, got addr %h data %h",
        name, expected.addr, expected.data, actual.addr, actual.data));
    end
  endtask

  task automatic check_checksum(input string name, input checksum_t expected,
                                input checksum_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("[FAIL] %s expected %h, got %h", name, expected, actual));
    end
  endtask

  task automatic check_level(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("[FAIL] %s expected %h, got %h", name, expected, actual));
    end
  endtask

  // Between copies nothing moves and the last checksum is held
  task automatic check_idle_outputs();
    check_level("busy", 1'b0, busy);
    check_level("done", 1'b0, done);
    check_level("mem_we", 1'b0, mem_we);
    check_checksum("checksum", last_sum, checksum);
  endtask

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------

  // Word k goes from ROM address src_base+k to memory address dst_base+k,
  // both wrapping at their own widths, and the sum wraps modulo 2^64
  task automatic compute_expected(input boot_request_t req);
    rom_addr_t src;
    mem_addr_t dst;
    int        k;
    exp_sum = '0;
    for (k = 0; k < int'(req.count); k++) begin
      src = req.src_base + rom_addr_t'(k);
      dst = req.dst_base + mem_addr_t'(k);
      exp_writes[rom_addr_t'(k)].addr = dst;
      exp_writes[rom_addr_t'(k)].data = model_rom[src];
      exp_sum = exp_sum + model_rom[src];
    end
  endtask

  function automatic boot_request_t build_request(input int src, input int dst, input int cnt);
    boot_request_t req;
    req.src_base = rom_addr_t'(src);
    req.dst_base = mem_addr_t'(dst);
    req.count    = word_count_t'(cnt);
    return req;
  endfunction

  function automatic boot_request_t random_request();
    return build_request(int'($urandom_range(0, 63)), int'($urandom_range(0, 65535)),
                         int'($urandom_range(0, 64)));
  endfunction

  // ------------------------------------------------------------
  // One copy, checked cycle by cycle
  // ------------------------------------------------------------

  // Cycle 0 is the cycle that carries start. Outputs are sampled on the
  // falling edge before new inputs go out, so every sample is settled
  task automatic run_request(input boot_request_t req, input int spurious_pct);
    int   done_cycle;
    int   c;
    int   gap;
    logic we_exp;
    compute_expected(req);
    done_cycle = (req.count == word_count_t'(0)) ? 1 : int'(req.count) + 2;

    @(negedge clk);
    check_idle_outputs();
    start   = 1'b1;
    request = req;

    for (c = 1; c <= done_cycle; c++) begin
      @(negedge clk);
      we_exp = (c >= 2) && (c <= int'(req.count) + 1);
      check_level("busy", c < done_cycle, busy);
      check_level("done", c == done_cycle, done);
      check_level("mem_we", we_exp, mem_we);
      if (we_exp) begin
        check_write("mem_write", exp_writes[rom_addr_t'(c - 2)], mem_write);
      end
      if (c == done_cycle) begin
        check_checksum("checksum", exp_sum, checksum);
      end

      // The request is only taken with an accepted start, so it is scrambled
      // here, and extra starts land only while busy is high
      request = random_request();
      if ((c < done_cycle) && (int'($urandom_range(0, 99)) < spurious_pct)) begin
        start = 1'b1;
      end else begin
        start = 1'b0;
      end
    end

    last_sum = exp_sum;
    gap = int'($urandom_range(0, 3));
    repeat (gap) begin
      @(negedge clk);
      check_idle_outputs();
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------

  initial begin
    int i;
    void'($urandom(32'hfb40_180a));
    reset        = 1'b1;
    start        = 1'b0;
    request      = '0;
    last_sum     = '0;

    $readmemh("boot_image.hex", model_rom);
    for (i = 0; i < rom_depth; i++) begin
      if ($isunknown(model_rom[rom_addr_t'(i)])) begin
        stop_with_failure("The boot image could not be read into the reference model");
      end
    end

    repeat (5) @(negedge clk);
    reset = 1'b0;

    // Outputs right after reset
    @(negedge clk);
    check_idle_outputs();

    // Empty copy, whole ROM, and ranges that wrap at the top of ROM or memory
    run_request(build_request(5, 'h1234, 0), 0);
    run_request(build_request(0, 'h0100, 64), 0);
    run_request(build_request(58, 'h2000, 12), 40);
    run_request(build_request(3, 'hfffd, 9), 40);
    run_request(build_request(37, 'hfff0, 64), 40);
    run_request(build_request(63, 'hffff, 1), 40);

    for (i = 0; i < num_random; i++) begin
      run_request(random_request(), 25);
    end

    @(negedge clk);
    check_idle_outputs();

    $display("Verification passed");
    $finish;
  end

  // Watchdog
  initial begin
    #(watchdog_ns);
    stop_with_failure("Timeout: the run did not finish in the time allowed for all requests");
  end

endmodule

// ==== verilog/boot_loader.sv ====
/*
  Boot image loader top level with the ROM, copy sequencer,
  word counter and copy datapath
*/

`timescale 1ns/1ps

module boot_loader (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  input  boot_pkg::boot_request_t request,
  output logic                    busy,
  output logic                    mem_we,
  output boot_pkg::mem_write_t    mem_write,
  output logic                    done,
  output boot_pkg::checksum_t     checksum
);

  import boot_pkg::*;

  // ------------------------------------------------------------
  // Internal wiring
  // ------------------------------------------------------------

  // Sequencer strobes
  logic load;
  logic step;
  logic rom_ce;
  logic data_valid;

  // Counter state back to the sequencer and datapath
  logic      count_empty;
  logic      last;
  rom_addr_t offset;

  // ROM read port
  rom_addr_t  rom_addr;
  data_word_t rom_data;

  // ------------------------------------------------------------
  // Instances
  // ------------------------------------------------------------

  boot_rom u_rom (
    .clk  (clk),
    .ce   (rom_ce),
    .addr (rom_addr),
    .dout (rom_data)
  );

  // The counter loads straight from the request on the start cycle
  word_counter u_counter (
    .clk    (clk),
    .reset  (reset),
    .load   (load),
    .count  (request.count),
    .step   (step),
    .offset (offset),
    .empty  (count_empty),
    .last   (last)
  );

  copy_fsm u_fsm (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .count_empty (count_empty),
    .last        (last),
    .load        (load),
    .step        (step),
    .rom_ce      (rom_ce),
    .data_valid  (data_valid),
    .busy        (busy),
    .done        (done)
  );

  copy_datapath u_datapath (
    .clk        (clk),
    .reset      (reset),
    .load       (load),
    .data_valid (data_valid),
    .request    (request),
    .offset     (offset),
    .rom_addr   (rom_addr),
    .rom_data   (rom_data),
    .mem_we     (mem_we),
    .mem_write  (mem_write),
    .checksum   (checksum)
  );

endmodule

// ==== verilog/boot_pkg.sv ====
/*
  Shared sizes, vector types, request and write structs
  and the copy state encoding of the boot image loader
*/

package boot_pkg;

  // ------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------

  // The boot ROM holds 64 words of 64 bits
  localparam int rom_addr_width = 6;
  localparam int rom_depth      = 64;
  localparam int data_width     = 64;

  // Destination memory is word addressed
  localparam int mem_addr_width = 16;

  // Image loaded into the ROM at elaboration
  localparam string image_file = "boot_image.hex";

  // ------------------------------------------------------------
  // Vector types
  // ------------------------------------------------------------

  typedef logic [rom_addr_width-1:0] rom_addr_t;
  typedef logic [data_width-1:0]     data_word_t;
  typedef logic [mem_addr_width-1:0] mem_addr_t;

  // One extra bit so that a full ROM copy of 64 words fits
  typedef logic [rom_addr_width:0]   word_count_t;

  // Additive checksum, wraps modulo 2^64
  typedef logic [data_width-1:0]     checksum_t;

  // ------------------------------------------------------------
  // Structs and state encoding
  // ------------------------------------------------------------

  typedef struct packed {
    rom_addr_t   src_base;
    mem_addr_t   dst_base;
    word_count_t count;
  } boot_request_t;

  typedef struct packed {
    mem_addr_t  addr;
    data_word_t data;
  } mem_write_t;

  typedef enum logic [1:0] {
    idle,
    reading,
    draining,
    finishing
  } copy_state_t;

endpackage

// ==== verilog/boot_rom.sv ====
/*
  Single-ported boot ROM with a registered read port,
  preloaded from the boot image file
*/

`timescale 1ns/1ps

module boot_rom (
  input  logic                clk,
  input  logic                ce,
  input  boot_pkg::rom_addr_t addr,
  output boot_pkg::data_word_t dout
);

  import boot_pkg::*;

  // Word storage, one entry per ROM address
  data_word_t rom_array [rom_depth];

  // Contents come from the image file once at startup
  // Each line of the file is one 64-bit word in hex
  initial begin
    $readmemh(image_file, rom_array);
  end

  // Read port
  // The addressed word shows on dout one cycle after ce
  // With ce low the last word read stays on the output
  always_ff @(posedge clk) begin
    if (ce) begin
      dout <= rom_array[addr];
    end
  end

endmodule

// ==== verilog/copy_datapath.sv ====
/*
  Source and destination address generation, the external
  write register and the 64-bit checksum accumulator
*/

`timescale 1ns/1ps

module copy_datapath (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    load,
  input  logic                    data_valid,
  input  boot_pkg::boot_request_t request,
  input  boot_pkg::rom_addr_t     offset,
  output boot_pkg::rom_addr_t     rom_addr,
  input  boot_pkg::data_word_t    rom_data,
  output logic                    mem_we,
  output boot_pkg::mem_write_t    mem_write,
  output boot_pkg::checksum_t     checksum
);

  import boot_pkg::*;

  // Source base kept for the whole copy
  rom_addr_t src_base_q;

  // Destination of the next word leaving the ROM
  mem_addr_t dst_ptr;

  rom_addr_t src_base_cur;

  // ------------------------------------------------------------
  // Source address
  // ------------------------------------------------------------

  // The first read goes out in the load cycle, before the request
  // register has been written, so the live request is used then
  assign src_base_cur = load ? request.src_base : src_base_q;

  // Adding in 6 bits wraps the read past the top of the ROM
  assign rom_addr = src_base_cur + offset;

  always_ff @(posedge clk) begin
    if (load) begin
      src_base_q <= request.src_base;
    end
  end

  // ------------------------------------------------------------
  // Destination address and write register
  // ------------------------------------------------------------

  // Pointer advances once per word, wrapping at 16 bits
  always_ff @(posedge clk) begin
    if (load) begin
      dst_ptr <= request.dst_base;
    end else if (data_valid) begin
      dst_ptr <= dst_ptr + mem_addr_t'(1);
    end
  end

  // Word and address are captured together as the ROM output settles
  always_ff @(posedge clk) begin
    if (data_valid) begin
      mem_write.addr <= dst_ptr;
      mem_write.data <= rom_data;
    end
  end

  // Write strobe follows the captured word by nothing, both appear together
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_we <= 1'b0;
    end else begin
      mem_we <= data_valid;
    end
  end

  // ------------------------------------------------------------
  // Checksum
  // ------------------------------------------------------------

  // Cleared when a request is taken and then holds past done
  // Sum wraps modulo 2^64
  always_ff @(posedge clk) begin
    if (reset) begin
      checksum <= '0;
    end else if (load) begin
      checksum <= '0;
    end else if (data_valid) begin
      checksum <= checksum + rom_data;
    end
  end

endmodule

// ==== verilog/copy_fsm.sv ====
/*
  Copy sequencer with read, drain and finish phases,
  driving the counter, the ROM enable and the data-valid strobe
*/

`timescale 1ns/1ps

module copy_fsm (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic count_empty,
  input  logic last,
  output logic load,
  output logic step,
  output logic rom_ce,
  output logic data_valid,
  output logic busy,
  output logic done
);

  import boot_pkg::*;

  copy_state_t state;
  copy_state_t state_next;

  // ------------------------------------------------------------
  // Next state and control strobes
  // ------------------------------------------------------------

  always_comb begin
    state_next = state;
    load       = 1'b0;
    step       = 1'b0;
    rom_ce     = 1'b0;

    case (state)
      // Busy is low in both states, so a start is taken in either
      idle, finishing: begin
        state_next = idle;
        if (start) begin
          load = 1'b1;
          if (count_empty) begin
            // Nothing to copy, report at once
            state_next = finishing;
          end else begin
            // First word is read in the start cycle itself
            rom_ce     = 1'b1;
            step       = 1'b1;
            state_next = last ? draining : reading;
          end
        end
      end

      // One ROM read per cycle until the final word has been issued
      reading: begin
        rom_ce = 1'b1;
        step   = 1'b1;
        if (last) begin
          state_next = draining;
        end
      end

      // Wait while the last word passes the ROM and the write register
      draining: begin
        if (!data_valid) begin
          state_next = finishing;
        end
      end

      default: begin
        state_next = idle;
      end
    endcase
  end

  // Busy drops in the same cycle that done is raised
  assign busy = (state == reading) || (state == draining);
  assign done = (state == finishing);

  // ------------------------------------------------------------
  // State register
  // ------------------------------------------------------------

  // ROM data is valid one cycle after each enabled read
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= idle;
      data_valid <= 1'b0;
    end else begin
      state      <= state_next;
      data_valid <= rom_ce;
    end
  end

endmodule

// ==== verilog/word_counter.sv ====
/*
  Down counter of words still to be read, with the running
  word offset and the empty and last-word flags
*/

`timescale 1ns/1ps

module word_counter (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  load,
  input  boot_pkg::word_count_t count,
  input  logic                  step,
  output boot_pkg::rom_addr_t   offset,
  output logic                  empty,
  output logic                  last
);

  import boot_pkg::*;

  word_count_t remaining_q;
  rom_addr_t   offset_q;

  // Values seen in the current cycle
  // On a load the new count and a zero offset are used at once, so the
  // first read can go out in the same cycle as the start
  word_count_t remaining_cur;
  rom_addr_t   offset_cur;

  assign remaining_cur = load ? count : remaining_q;
  assign offset_cur    = load ? '0 : offset_q;

  // Flags for the state machine
  assign offset = offset_cur;
  assign empty  = (remaining_cur == word_count_t'(0));
  assign last   = (remaining_cur == word_count_t'(1));

  // ------------------------------------------------------------
  // Counter registers
  // ------------------------------------------------------------

  // A step consumes one word, and it may land in the load cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      remaining_q <= '0;
      offset_q    <= '0;
    end else if (load || step) begin
      if (step) begin
        remaining_q <= remaining_cur - word_count_t'(1);
        offset_q    <= offset_cur + rom_addr_t'(1);
      end else begin
        remaining_q <= remaining_cur;
        offset_q    <= offset_cur;
      end
    end
  end

endmodule
